// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = backend_tb
FILELIST  = backend.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== backend.f ====
logic/backend_pkg.sv
logic/idu_decoder.sv
logic/iru_rename.sv
logic/isu_issue.sv
logic/exu_alu.sv
logic/rob.sv
logic/backend.sv
test/backend_assert.sv
test/backend_tb.sv

// ==== logic/backend.sv ====
`timescale 1ns/100ps
module backend (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                ibuffer_instr_valid,
    input  backend_pkg::instr_t ibuffer_inst_out,
    input  backend_pkg::pc_t    ibuffer_pc_out,
    output logic                ibuffer_instr_ready,
    output logic                commit_valid,
    output backend_pkg::pc_t    commit_pc,
    output backend_pkg::lreg_t  commit_lrd,
    output backend_pkg::xlen_t  commit_result
);
    // decoder to rename
    logic                 rename_stall;
    logic                 dec_valid;
    backend_pkg::pc_t     dec_pc;
    backend_pkg::lreg_t   dec_lrs1;
    backend_pkg::lreg_t   dec_lrs2;
    backend_pkg::lreg_t   dec_lrd;
    backend_pkg::xlen_t   dec_imm;
    logic                 dec_src2_is_imm;
    backend_pkg::alu_op_t dec_alu_op;
    logic                 dec_need_to_wb;
    // rename to issue and rob
    logic                 issue_stall;
    logic                 ren_valid;
    backend_pkg::pc_t     ren_pc;
    backend_pkg::preg_t   ren_prs1;
    backend_pkg::preg_t   ren_prs2;
    backend_pkg::preg_t   ren_prd;
    backend_pkg::preg_t   ren_old_prd;
    backend_pkg::lreg_t   ren_lrd;
    backend_pkg::xlen_t   ren_imm;
    logic                 ren_src2_is_imm;
    backend_pkg::alu_op_t ren_alu_op;
    logic                 ren_need_to_wb;
    backend_pkg::robid_t  ren_robid;
    logic                 rob_alloc;
    // issue to alu
    logic                 issue_valid;
    backend_pkg::xlen_t   issue_src1;
    backend_pkg::xlen_t   issue_src2;
    backend_pkg::alu_op_t issue_alu_op;
    backend_pkg::preg_t   issue_prd;
    logic                 issue_need_to_wb;
    backend_pkg::robid_t  issue_robid;
    backend_pkg::pc_t     issue_pc;
    // writeback and commit
    logic                 intwb_valid;
    backend_pkg::preg_t   intwb_prd;
    backend_pkg::robid_t  intwb_robid;
    backend_pkg::xlen_t   intwb_result;
    backend_pkg::preg_t   commit_old_prd;
    logic                 commit_need_to_wb;

    idu_decoder u_idu (.dec_instr(), .*);

    iru_rename u_iru (.*);

    isu_issue u_isu (.*);

    exu_alu u_exu (.intwb_need_to_wb(), .*);

    rob u_rob (.*);

endmodule

// ==== logic/backend_pkg.sv ====
package backend_pkg;

    localparam int XLEN         = 64;
    localparam int PC_WIDTH     = 64;
    localparam int LREG_NUM     = 32;
    localparam int PREG_NUM     = 64;
    localparam int ROB_SIZE     = 16;
    localparam int ROB_SIZE_LOG = 4;
    localparam int FL_SIZE      = PREG_NUM - LREG_NUM;   // pregs not mapped at reset
    localparam int FL_SIZE_LOG  = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [PC_WIDTH-1:0]         pc_t;
    typedef logic [31:0]                 instr_t;
    typedef logic [$clog2(LREG_NUM)-1:0] lreg_t;
    typedef logic [$clog2(PREG_NUM)-1:0] preg_t;
    typedef logic [ROB_SIZE_LOG:0]       robid_t;   // msb is the wrap bit

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC
    } alu_op_t;

endpackage

// ==== logic/exu_alu.sv ====
`timescale 1ns/100ps
module exu_alu (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  backend_pkg::xlen_t   issue_src1,
    input  backend_pkg::xlen_t   issue_src2,
    input  backend_pkg::alu_op_t issue_alu_op,
    input  backend_pkg::preg_t   issue_prd,
    input  logic                 issue_need_to_wb,
    input  backend_pkg::robid_t  issue_robid,
    input  backend_pkg::pc_t     issue_pc,
    output logic                 intwb_valid,
    output backend_pkg::preg_t   intwb_prd,
    output logic                 intwb_need_to_wb,
    output backend_pkg::robid_t  intwb_robid,
    output backend_pkg::xlen_t   intwb_result
);
    backend_pkg::xlen_t result;
    logic [5:0]         shamt;

    assign shamt = issue_src2[5:0];   // rv64 shift amount

    always_comb begin
        case (issue_alu_op)
            backend_pkg::ALU_SUB:   result = issue_src1 - issue_src2;
            backend_pkg::ALU_SLL:   result = issue_src1 << shamt;
            backend_pkg::ALU_SLT:   result = backend_pkg::xlen_t'($signed(issue_src1) <
                                                                   $signed(issue_src2));
            backend_pkg::ALU_SLTU:  result = backend_pkg::xlen_t'(issue_src1 < issue_src2);
            backend_pkg::ALU_XOR:   result = issue_src1 ^ issue_src2;
            backend_pkg::ALU_SRL:   result = issue_src1 >> shamt;
            backend_pkg::ALU_SRA:   result = $unsigned($signed(issue_src1) >>> shamt);
            backend_pkg::ALU_OR:    result = issue_src1 | issue_src2;
            backend_pkg::ALU_AND:   result = issue_src1 & issue_src2;
            backend_pkg::ALU_LUI:   result = issue_src2;
            backend_pkg::ALU_AUIPC: result = issue_pc + issue_src2;
            default:                result = issue_src1 + issue_src2;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            intwb_valid <= 1'b0;
        end else begin
            intwb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            intwb_prd        <= issue_prd;
            intwb_need_to_wb <= issue_need_to_wb;
            intwb_robid      <= issue_robid;
            intwb_result     <= result;
        end
    end

endmodule

// ==== logic/idu_decoder.sv ====
`timescale 1ns/100ps
module idu_decoder (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 ibuffer_instr_valid,
    input  backend_pkg::instr_t  ibuffer_inst_out,
    input  backend_pkg::pc_t     ibuffer_pc_out,
    input  logic                 rename_stall,
    output logic                 ibuffer_instr_ready,
    output logic                 dec_valid,
    output backend_pkg::pc_t     dec_pc,
    output backend_pkg::instr_t  dec_instr,
    output backend_pkg::lreg_t   dec_lrs1,
    output backend_pkg::lreg_t   dec_lrs2,
    output backend_pkg::lreg_t   dec_lrd,
    output backend_pkg::xlen_t   dec_imm,
    output logic                 dec_src2_is_imm,
    output backend_pkg::alu_op_t dec_alu_op,
    output logic                 dec_need_to_wb
);
    backend_pkg::instr_t  inst;
    backend_pkg::xlen_t   imm_i;
    backend_pkg::xlen_t   imm_u;
    backend_pkg::alu_op_t f3_op;
    backend_pkg::alu_op_t op;
    backend_pkg::lreg_t   lrs1;
    backend_pkg::lreg_t   lrs2;
    backend_pkg::lreg_t   lrd;
    backend_pkg::xlen_t   imm;
    logic                 src2_is_imm;
    logic                 supported;

    assign inst  = ibuffer_inst_out;
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign ibuffer_instr_ready = ~rename_stall;

    always_comb begin
        case (inst[14:12])
            3'b000:  f3_op = (inst[30] && inst[5]) ? backend_pkg::ALU_SUB : backend_pkg::ALU_ADD; // no subi
            3'b001:  f3_op = backend_pkg::ALU_SLL;
            3'b010:  f3_op = backend_pkg::ALU_SLT;
            3'b011:  f3_op = backend_pkg::ALU_SLTU;
            3'b100:  f3_op = backend_pkg::ALU_XOR;
            3'b101:  f3_op = inst[30] ? backend_pkg::ALU_SRA : backend_pkg::ALU_SRL;
            3'b110:  f3_op = backend_pkg::ALU_OR;
            default: f3_op = backend_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op          = f3_op;
        lrs1        = inst[19:15];
        lrs2        = '0;
        lrd         = inst[11:7];
        imm         = imm_i;
        src2_is_imm = 1'b1;
        supported   = 1'b1;
        case (inst[6:0])
            backend_pkg::OPC_OP: begin
                lrs2        = inst[24:20];
                src2_is_imm = 1'b0;
                supported   = ~inst[25];   // M extension not here
            end
            backend_pkg::OPC_OP_IMM: supported = 1'b1;
            backend_pkg::OPC_LUI: begin
                op   = backend_pkg::ALU_LUI;
                lrs1 = '0;
                imm  = imm_u;
            end
            backend_pkg::OPC_AUIPC: begin
                op   = backend_pkg::ALU_AUIPC;
                lrs1 = '0;
                imm  = imm_u;
            end
            default: supported = 1'b0;
        endcase
        if (!supported) begin   // becomes add x0, x0, 0
            op          = backend_pkg::ALU_ADD;
            lrs1        = '0;
            lrs2        = '0;
            lrd         = '0;
            imm         = '0;
            src2_is_imm = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (!rename_stall) begin
            dec_valid <= ibuffer_instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ibuffer_instr_valid && ibuffer_instr_ready) begin
            dec_pc          <= ibuffer_pc_out;
            dec_instr       <= inst;
            dec_lrs1        <= lrs1;
            dec_lrs2        <= lrs2;
            dec_lrd         <= lrd;
            dec_imm         <= imm;
            dec_src2_is_imm <= src2_is_imm;
            dec_alu_op      <= op;
            dec_need_to_wb  <= (lrd != '0);
        end
    end

endmodule

// ==== logic/iru_rename.sv ====
`timescale 1ns/100ps
module iru_rename (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 dec_valid,
    input  backend_pkg::pc_t     dec_pc,
    input  backend_pkg::lreg_t   dec_lrs1,
    input  backend_pkg::lreg_t   dec_lrs2,
    input  backend_pkg::lreg_t   dec_lrd,
    input  backend_pkg::xlen_t   dec_imm,
    input  logic                 dec_src2_is_imm,
    input  backend_pkg::alu_op_t dec_alu_op,
    input  logic                 dec_need_to_wb,
    input  logic                 issue_stall,
    input  logic                 commit_valid,
    input  logic                 commit_need_to_wb,
    input  backend_pkg::preg_t   commit_old_prd,
    output logic                 rename_stall,
    output logic                 ren_valid,
    output backend_pkg::pc_t     ren_pc,
    output backend_pkg::preg_t   ren_prs1,
    output backend_pkg::preg_t   ren_prs2,
    output backend_pkg::preg_t   ren_prd,
    output backend_pkg::preg_t   ren_old_prd,
    output backend_pkg::lreg_t   ren_lrd,
    output backend_pkg::xlen_t   ren_imm,
    output logic                 ren_src2_is_imm,
    output backend_pkg::alu_op_t ren_alu_op,
    output logic                 ren_need_to_wb,
    output backend_pkg::robid_t  ren_robid,
    output logic                 rob_alloc
);
    backend_pkg::preg_t                  rat       [backend_pkg::LREG_NUM];
    backend_pkg::preg_t                  free_list [backend_pkg::FL_SIZE];
    logic [backend_pkg::FL_SIZE_LOG-1:0] fl_head;
    logic [backend_pkg::FL_SIZE_LOG-1:0] fl_tail;
    logic [backend_pkg::FL_SIZE_LOG:0]   fl_count;
    logic [backend_pkg::ROB_SIZE_LOG:0]  rob_count;
    backend_pkg::robid_t                 rob_tail;
    logic                                ren_load;
    logic                                fl_pop;
    logic                                fl_push;

    // rob_count msb set means ROB_SIZE entries in flight
    assign rename_stall = (ren_valid && issue_stall) || (fl_count == '0) ||
                          rob_count[backend_pkg::ROB_SIZE_LOG];
    assign ren_load  = dec_valid && !rename_stall;
    assign fl_pop    = ren_load && dec_need_to_wb;
    assign fl_push   = commit_valid && commit_need_to_wb;
    assign rob_alloc = ren_valid && !issue_stall;   // entry moves on to issue

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < backend_pkg::LREG_NUM; i++) begin
                rat[i] <= backend_pkg::preg_t'(i);   // identity map
            end
            for (int i = 0; i < backend_pkg::FL_SIZE; i++) begin
                free_list[i] <= backend_pkg::preg_t'(backend_pkg::LREG_NUM + i);
            end
            fl_head   <= '0;
            fl_tail   <= '0;
            fl_count  <= {1'b1, {backend_pkg::FL_SIZE_LOG{1'b0}}};   // all free
            rob_count <= '0;
            rob_tail  <= '0;
        end else begin
            if (fl_pop) begin
                rat[dec_lrd] <= free_list[fl_head];
                fl_head      <= fl_head + 1'b1;
            end
            if (fl_push) begin
                free_list[fl_tail] <= commit_old_prd;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (fl_pop && !fl_push) begin
                fl_count <= fl_count - 1'b1;
            end else if (fl_push && !fl_pop) begin
                fl_count <= fl_count + 1'b1;
            end
            if (ren_load) begin
                rob_tail <= rob_tail + 1'b1;
            end
            if (ren_load && !commit_valid) begin
                rob_count <= rob_count + 1'b1;
            end else if (commit_valid && !ren_load) begin
                rob_count <= rob_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ren_valid <= 1'b0;
        end else if (rob_alloc || !ren_valid) begin
            ren_valid <= ren_load;   // bubble while out of pregs or ROB ids
        end
    end

    always_ff @(posedge clock) begin
        if (ren_load) begin
            ren_pc          <= dec_pc;
            ren_prs1        <= rat[dec_lrs1];
            ren_prs2        <= rat[dec_lrs2];
            ren_prd         <= dec_need_to_wb ? free_list[fl_head] : '0;
            ren_old_prd     <= rat[dec_lrd];
            ren_lrd         <= dec_lrd;
            ren_imm         <= dec_imm;
            ren_src2_is_imm <= dec_src2_is_imm;
            ren_alu_op      <= dec_alu_op;
            ren_need_to_wb  <= dec_need_to_wb;
            ren_robid       <= rob_tail;
        end
    end

endmodule

// ==== logic/isu_issue.sv ====
`timescale 1ns/100ps
module isu_issue (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 ren_valid,
    input  backend_pkg::pc_t     ren_pc,
    input  backend_pkg::preg_t   ren_prs1,
    input  backend_pkg::preg_t   ren_prs2,
    input  backend_pkg::preg_t   ren_prd,
    input  backend_pkg::xlen_t   ren_imm,
    input  logic                 ren_src2_is_imm,
    input  backend_pkg::alu_op_t ren_alu_op,
    input  logic                 ren_need_to_wb,
    input  backend_pkg::robid_t  ren_robid,
    input  logic                 intwb_valid,
    input  backend_pkg::preg_t   intwb_prd,
    input  backend_pkg::xlen_t   intwb_result,
    output logic                 issue_stall,
    output logic                 issue_valid,
    output backend_pkg::xlen_t   issue_src1,
    output backend_pkg::xlen_t   issue_src2,
    output backend_pkg::alu_op_t issue_alu_op,
    output backend_pkg::preg_t   issue_prd,
    output logic                 issue_need_to_wb,
    output backend_pkg::robid_t  issue_robid,
    output backend_pkg::pc_t     issue_pc
);
    backend_pkg::xlen_t            prf [backend_pkg::PREG_NUM];
    logic [backend_pkg::PREG_NUM-1:0] busy;
    logic                          iss_valid;
    backend_pkg::preg_t            iss_prs1;
    backend_pkg::preg_t            iss_prs2;
    backend_pkg::xlen_t            iss_imm;
    logic                          iss_src2_is_imm;
    logic                          src_ready;
    logic                          iss_load;

    // imm forms carry prs2 = 0, never busy
    assign src_ready   = !busy[iss_prs1] && !busy[iss_prs2];
    assign issue_valid = iss_valid && src_ready;
    assign issue_stall = iss_valid && !src_ready;
    assign iss_load    = ren_valid && !issue_stall;
    assign issue_src1  = prf[iss_prs1];
    assign issue_src2  = iss_src2_is_imm ? iss_imm : prf[iss_prs2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < backend_pkg::PREG_NUM; i++) begin
                prf[i] <= '0;
            end
        end else begin
            if (intwb_valid) begin
                busy[intwb_prd] <= 1'b0;
                if (intwb_prd != '0) begin   // preg 0 holds x0
                    prf[intwb_prd] <= intwb_result;
                end
            end
            if (iss_load && ren_need_to_wb) begin
                busy[ren_prd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else if (!issue_stall) begin
            iss_valid <= ren_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (iss_load) begin
            iss_prs1         <= ren_prs1;
            iss_prs2         <= ren_prs2;
            iss_imm          <= ren_imm;
            iss_src2_is_imm  <= ren_src2_is_imm;
            issue_alu_op     <= ren_alu_op;
            issue_prd        <= ren_prd;
            issue_need_to_wb <= ren_need_to_wb;
            issue_robid      <= ren_robid;
            issue_pc         <= ren_pc;
        end
    end

endmodule

// ==== logic/rob.sv ====
`timescale 1ns/100ps
module rob (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                rob_alloc,
    input  backend_pkg::robid_t ren_robid,
    input  backend_pkg::pc_t    ren_pc,
    input  backend_pkg::lreg_t  ren_lrd,
    input  backend_pkg::preg_t  ren_old_prd,
    input  logic                ren_need_to_wb,
    input  logic                intwb_valid,
    input  backend_pkg::robid_t intwb_robid,
    input  backend_pkg::xlen_t  intwb_result,
    output logic                commit_valid,
    output backend_pkg::pc_t    commit_pc,
    output backend_pkg::lreg_t  commit_lrd,
    output backend_pkg::preg_t  commit_old_prd,
    output logic                commit_need_to_wb,
    output backend_pkg::xlen_t  commit_result
);
    logic [backend_pkg::ROB_SIZE-1:0]     entry_valid;
    logic [backend_pkg::ROB_SIZE-1:0]     entry_done;
    logic [backend_pkg::ROB_SIZE-1:0]     need_q;
    backend_pkg::pc_t                     pc_q      [backend_pkg::ROB_SIZE];
    backend_pkg::lreg_t                   lrd_q     [backend_pkg::ROB_SIZE];
    backend_pkg::preg_t                   old_prd_q [backend_pkg::ROB_SIZE];
    backend_pkg::xlen_t                   result_q  [backend_pkg::ROB_SIZE];
    backend_pkg::robid_t                  head;   // follows ids from rename
    logic [backend_pkg::ROB_SIZE_LOG-1:0] head_idx;
    logic [backend_pkg::ROB_SIZE_LOG-1:0] alloc_idx;
    logic [backend_pkg::ROB_SIZE_LOG-1:0] wb_idx;

    assign head_idx  = head[backend_pkg::ROB_SIZE_LOG-1:0];
    assign alloc_idx = ren_robid[backend_pkg::ROB_SIZE_LOG-1:0];
    assign wb_idx    = intwb_robid[backend_pkg::ROB_SIZE_LOG-1:0];

    assign commit_valid      = entry_valid[head_idx] && entry_done[head_idx];
    assign commit_pc         = pc_q[head_idx];
    assign commit_lrd        = lrd_q[head_idx];
    assign commit_old_prd    = old_prd_q[head_idx];
    assign commit_need_to_wb = need_q[head_idx];
    assign commit_result     = result_q[head_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            entry_done  <= '0;
            head        <= '0;
        end else begin
            if (commit_valid) begin
                entry_valid[head_idx] <= 1'b0;
                head                  <= head + 1'b1;
            end
            if (rob_alloc) begin
                entry_valid[alloc_idx] <= 1'b1;
                entry_done[alloc_idx]  <= 1'b0;
            end
            if (intwb_valid) begin
                entry_done[wb_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rob_alloc) begin
            pc_q[alloc_idx]      <= ren_pc;
            lrd_q[alloc_idx]     <= ren_lrd;
            old_prd_q[alloc_idx] <= ren_old_prd;
            need_q[alloc_idx]    <= ren_need_to_wb;
        end
        if (intwb_valid) begin
            result_q[wb_idx] <= intwb_result;   // retirement trace value
        end
    end

endmodule

// ==== test/backend_assert.sv ====
`timescale 1ns/100ps
module backend_assert (
    input logic                                 clock,
    input logic                                 rst_n,
    input logic                                 rob_alloc,
    input logic                                 commit_valid,
    input logic                                 intwb_valid,
    input logic [backend_pkg::ROB_SIZE_LOG-1:0] alloc_idx,
    input logic [backend_pkg::ROB_SIZE_LOG-1:0] head_idx,
    input logic [backend_pkg::ROB_SIZE_LOG-1:0] wb_idx,
    input logic [backend_pkg::ROB_SIZE-1:0]     entry_valid,
    input logic [backend_pkg::ROB_SIZE-1:0]     entry_done
);
    // a new entry may only land on a free slot, or on the one leaving now
    rob_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        rob_alloc |-> !entry_valid[alloc_idx] || (commit_valid && head_idx == alloc_idx))
        else $error("reorder buffer allocated an occupied entry");

    // done bits only come from a result for a live, still open entry
    wb_hits_open_entry: assert property (@(posedge clock) disable iff (!rst_n)
        intwb_valid |-> entry_valid[wb_idx] && !entry_done[wb_idx])
        else $error("writeback to an entry that is free or already complete");

    commit_after_wb: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |-> !(intwb_valid && wb_idx == head_idx))
        else $error("commit of a head entry whose result is still arriving");

    reset_quiet: assert property (@(posedge clock) !rst_n |-> !commit_valid)
        else $error("commit_valid high during reset");
endmodule

bind rob backend_assert u_rob_assert (
    .clock        (clock),
    .rst_n        (rst_n),
    .rob_alloc    (rob_alloc),
    .commit_valid (commit_valid),
    .intwb_valid  (intwb_valid),
    .alloc_idx    (alloc_idx),
    .head_idx     (head_idx),
    .wb_idx       (wb_idx),
    .entry_valid  (entry_valid),
    .entry_done   (entry_done)
);

// ==== test/backend_golden.txt ====
// test  instr  lrd  value_hi  value_lo  count
// one record per line, count repeats the instruction back to back
2 00500093 01 00000000 00000005 1
2 12345137 02 00000000 12345000 1
2 00001197 03 00000000 80001008 1
2 80000237 04 FFFFFFFF 80000000 1
2 FFF00393 07 FFFFFFFF FFFFFFFF 1
3 00208433 08 00000000 12345005 1
3 401404B3 09 00000000 12345000 1
3 00149533 0A 00000002 468A0000 1
3 401255B3 0B FFFFFFFF FC000000 1
3 00125633 0C 07FFFFFF FC000000 1
3 0015A6B3 0D 00000000 00000001 1
3 0015B733 0E 00000000 00000000 1
3 007447B3 0F FFFFFFFF EDCBAFFA 1
3 00A0E833 10 00000002 468A0005 1
3 00F878B3 11 00000002 448A0000 1
4 12300313 06 00000000 00000123 28
5 00708013 00 00000000 00000000 1
5 00100933 12 00000000 00000005 1
5 0000000F 00 00000000 00000000 1

// ==== test/backend_tb.sv ====
`timescale 1ns/100ps
module backend_tb;
    localparam int MAX_REC = 32;
    localparam int MAX_EXP = 128;
    localparam int TIMEOUT = 200;

    logic                ibuffer_instr_valid;
    logic                clock;
    logic                rst_n;
    backend_pkg::instr_t ibuffer_inst_out;
    backend_pkg::pc_t    ibuffer_pc_out;
    logic                ibuffer_instr_ready;
    logic                commit_valid;
    backend_pkg::pc_t    commit_pc;
    backend_pkg::lreg_t  commit_lrd;
    backend_pkg::xlen_t  commit_result;

    logic [31:0]         golden [MAX_REC*6];
    backend_pkg::instr_t exp_instr [MAX_EXP];
    backend_pkg::pc_t    exp_pc [MAX_EXP];
    backend_pkg::lreg_t  exp_lrd [MAX_EXP];
    backend_pkg::xlen_t  exp_val [MAX_EXP];
    int                  exp_test [MAX_EXP];
    int                  exp_total;
    int                  commit_count;
    int                  errors;
    int                  test_errors [8];
    int                  mon_idx;
    logic                timed_out;
    logic [31:0]         lfsr;

    backend UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // taps 32 22 2 1
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_pc(input string name, input backend_pkg::pc_t got,
                            input backend_pkg::pc_t exp, input int t);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
            test_errors[t]++;
        end
    endtask

    task automatic check_lreg(input string name, input backend_pkg::lreg_t got,
                              input backend_pkg::lreg_t exp, input int t);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
            test_errors[t]++;
        end
    endtask

    task automatic check_xlen(input string name, input backend_pkg::xlen_t got,
                              input backend_pkg::xlen_t exp, input int t);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
            test_errors[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d: %s (%0d errors)", t, (test_errors[t] == 0) ? "ok" : "failed",
                 test_errors[t]);
    endtask

    task automatic send_instr(input backend_pkg::instr_t inst, input backend_pkg::pc_t pc);
        int cycles;
        @(posedge clock);
        ibuffer_instr_valid <= 1'b1;
        ibuffer_inst_out    <= inst;
        ibuffer_pc_out      <= pc;
        cycles = 0;
        @(negedge clock);
        while (!ibuffer_instr_ready && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!ibuffer_instr_ready) begin
            $display("ERROR: ibuffer_instr_ready stayed low for %0d cycles at pc %h",
                     TIMEOUT, pc);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clock);
        ibuffer_instr_valid <= 1'b0;
        repeat (n - 1) @(posedge clock);
    endtask

    // commit is combinational from the ROB head, stable at the falling edge
    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            if (commit_count >= exp_total) begin
                $display("ERROR: commit at pc %h beyond the last golden record", commit_pc);
                errors++;
                test_errors[6]++;
            end else begin
                mon_idx = commit_count;
                check_pc("commit_pc", commit_pc, exp_pc[mon_idx], exp_test[mon_idx]);
                check_lreg("commit_lrd", commit_lrd, exp_lrd[mon_idx], exp_test[mon_idx]);
                if (exp_lrd[mon_idx] != '0) begin   // x0 carries no value
                    check_xlen("commit_result", commit_result, exp_val[mon_idx],
                               exp_test[mon_idx]);
                end
                if (mon_idx == exp_total - 1 || exp_test[mon_idx + 1] != exp_test[mon_idx]) begin
                    report_test(exp_test[mon_idx]);
                end
            end
            commit_count++;
        end
    end

    initial begin
        int n;
        int gap;
        int cycles;
        int seen;
        rst_n               = 1'b0;
        ibuffer_instr_valid = 1'b0;
        ibuffer_inst_out    = '0;
        ibuffer_pc_out      = '0;
        timed_out           = 1'b0;
        errors              = 0;
        commit_count        = 0;
        lfsr                = 32'h64d3_000e;
        for (int i = 0; i < 8; i++) test_errors[i] = 0;
        for (int i = 0; i < MAX_REC * 6; i++) golden[i] = '0;
        $readmemh("test/backend_golden.txt", golden);
        n = 0;
        for (int r = 0; r < MAX_REC; r++) begin
            if (golden[r*6] == 0) break;
            for (int k = 0; k < int'(golden[r*6+5]); k++) begin
                exp_test[n]  = int'(golden[r*6]);
                exp_instr[n] = golden[r*6+1];
                exp_lrd[n]   = backend_pkg::lreg_t'(golden[r*6+2]);
                exp_val[n]   = {golden[r*6+3], golden[r*6+4]};
                exp_pc[n]    = 64'h8000_0000 + (backend_pkg::pc_t'(n) << 2);
                n++;
            end
        end
        exp_total = n;

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        repeat (3) begin   // nothing sent yet
            @(negedge clock);
            if (!ibuffer_instr_ready) begin
                $display("ERROR: ibuffer_instr_ready low after reset");
                errors++;
                test_errors[1]++;
            end
            if (commit_valid) begin
                $display("ERROR: commit_valid high before any instruction was sent");
                errors++;
                test_errors[1]++;
            end
        end
        report_test(1);

        for (int i = 0; i < exp_total && !timed_out; i++) begin
            send_instr(exp_instr[i], exp_pc[i]);
            if (exp_test[i] != 4) begin   // test 4 stays a back to back burst
                take_bits(2, gap);
                if (gap > 0) idle_cycles(gap);
            end
        end
        @(posedge clock);
        ibuffer_instr_valid <= 1'b0;

        cycles = 0;
        seen   = commit_count;
        while (commit_count < exp_total && cycles < TIMEOUT && !timed_out) begin
            @(posedge clock);
            if (commit_count != seen) begin
                seen   = commit_count;
                cycles = 0;
            end else begin
                cycles++;
            end
        end
        if (commit_count < exp_total) begin
            $display("ERROR: only %0d of %0d instructions committed before the timeout",
                     commit_count, exp_total);
            timed_out = 1'b1;
            errors++;
        end
        repeat (10) @(posedge clock);   // room for stray commits
        if (commit_count != exp_total) begin
            $display("ERROR: %0d commits seen but %0d instructions were sent",
                     commit_count, exp_total);
            errors++;
            test_errors[6]++;
        end
        report_test(6);
        $display("summary: %0d commits, %0d expected, %0d errors",
                 commit_count, exp_total, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule
